/* sim.f */
bridge_pkg.sv
bus_if.sv
port_engine.sv
axi_arbiter.sv
mem_bridge_top.sv
tb_mem_bridge_assertions.sv
tb_mem_bridge.sv

/* Makefile */
# Verilator build and run of the bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_bridge
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat sim.f))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_mem_bridge.sv */
//----------------------------------------------------------
// line region is words 0..511, word region is 512..1023
// slave memory of 1 K words, R and B returned in order
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_mem_bridge;

	localparam int NUM_RAND = 40;                   // per port in the mixed test
	localparam int LIMIT    = (6 + 2 * NUM_RAND) * 200;

	logic clk, rst;
	logic line_rd_req, line_rd_rdy, line_ret_valid, line_ret_last;
	logic line_wr_req, line_wr_rdy;
	logic word_rd_req, word_rd_rdy, word_ret_valid, word_ret_last;
	logic word_wr_req, word_wr_rdy;
	bridge_pkg::addr_t line_rd_addr, line_wr_addr, word_rd_addr, word_wr_addr;
	bridge_pkg::word_t line_ret_data, word_ret_data, word_wr_data;
	bridge_pkg::strb_t line_wr_strb, word_wr_strb;
	bridge_pkg::size_t word_rd_size, word_wr_size;
	bridge_pkg::line_t line_wr_data;
	bridge_pkg::id_t   arid, rid, awid, bid;
	bridge_pkg::addr_t araddr, awaddr;
	bridge_pkg::len_t  arlen, awlen;
	bridge_pkg::size_t arsize, awsize;
	bridge_pkg::word_t rdata, wdata;
	bridge_pkg::strb_t wstrb;
	logic arvalid, arready, rlast, rvalid, rready;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

	logic [31:0] rng = 32'h834d_3a82;
	logic [31:0] ref_mem [1024];
	logic [31:0] mem [1024];                       // slave contents
	int          rq_addr[$], rq_len[$], rq_id[$];
	int          wq_addr[$], wq_len[$], wq_id[$];
	int          bq_id[$];
	int          r_beat, w_beat;
	bit          b_seen [16];
	bit          line_rd_open, word_rd_open;
	bridge_pkg::size_t exp_word_size;
	bridge_pkg::size_t exp_word_wr_size;
	int          errors, checks, cycles;

	mem_bridge_top DUT (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// byte merge under strobe
	function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] nw, logic [3:0] strb);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				r[8*b +: 8] = nw[8*b +: 8];
		return r;
	endfunction

	function automatic void compare_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endfunction

	//----------------------------------------------------------
	// AXI slave model, sample on rise, drive on fall
	//----------------------------------------------------------
	always @(posedge clk)
	begin
		int idx;
		if (rst)
		begin
			// ready follows the transactions the slave still owes
			compare_value("rready", 32'(rready), 32'(rq_id.size() != 0));
			compare_value("bready", 32'(bready), 32'(wq_id.size() + bq_id.size() != 0));
			if (arvalid && arready)
			begin
				compare_value("arlen", 32'(arlen), (arid == bridge_pkg::LINE_ID) ? 15 : 0);
				compare_value("arsize", 32'(arsize), (arid == bridge_pkg::LINE_ID) ?
					32'(bridge_pkg::SIZE_WORD) : 32'(exp_word_size));
				assert (arid == bridge_pkg::LINE_ID || arid == bridge_pkg::WORD_ID)
				else
				begin
					$display("read address carries an unknown id");
					errors++;
				end
				rq_addr.push_back(int'(araddr));
				rq_len.push_back(int'(arlen));
				rq_id.push_back(int'(arid));
			end
			if (rvalid && rready)
			begin
				r_beat++;
				if (rlast)
				begin
					void'(rq_addr.pop_front());
					void'(rq_len.pop_front());
					void'(rq_id.pop_front());
					r_beat = 0;
				end
			end
			if (awvalid && awready)
			begin
				compare_value("awlen", 32'(awlen), (awid == bridge_pkg::LINE_ID) ? 15 : 0);
				compare_value("awsize", 32'(awsize), (awid == bridge_pkg::LINE_ID) ?
					32'(bridge_pkg::SIZE_WORD) : 32'(exp_word_wr_size));
				wq_addr.push_back(int'(awaddr));
				wq_len.push_back(int'(awlen));
				wq_id.push_back(int'(awid));
			end
			if (wvalid && wready)
			begin
				if (wq_len.size() == 0)
				begin
					$display("write data arrived before its address");
					errors++;
				end
				else
				begin
					compare_value("wlast", 32'(wlast), 32'(w_beat == wq_len[0]));
					idx = ((wq_addr[0] >> 2) + w_beat) & 1023;
					mem[idx] = merge(mem[idx], wdata, wstrb);
					w_beat++;
					if (wlast)
					begin
						bq_id.push_back(wq_id[0]);
						void'(wq_addr.pop_front());
						void'(wq_len.pop_front());
						void'(wq_id.pop_front());
						w_beat = 0;
					end
				end
			end
			if (bvalid && bready)
			begin
				b_seen[bid] = 1'b1;
				void'(bq_id.pop_front());
			end
		end
	end

	always @(negedge clk)
	begin
		int idx;
		if (rst)
		begin
			arready = next_rand() % 4 != 0;
			awready = next_rand() % 4 != 0;
			wready  = next_rand() % 3 != 0;
			rvalid  = (rq_id.size() > 0) && (next_rand() % 3 != 0);
			if (rq_id.size() > 0)
			begin
				idx   = ((rq_addr[0] >> 2) + r_beat) & 1023;
				rdata = mem[idx];
				rid   = bridge_pkg::id_t'(rq_id[0]);
				rlast = (r_beat == rq_len[0]);
			end
			bvalid = (bq_id.size() > 0) && (next_rand() % 3 != 0);
			if (bq_id.size() > 0)
				bid = bridge_pkg::id_t'(bq_id[0]);
		end
	end

	// no return beat without an open read
	always @(posedge clk)
	begin
		assert (!line_ret_valid || line_rd_open)
		else
		begin
			$display("line port returned data with no read open");
			errors++;
		end
		assert (!word_ret_valid || word_rd_open)
		else
		begin
			$display("word port returned data with no read open");
			errors++;
		end
	end

	//----------------------------------------------------------
	// requester tasks
	//----------------------------------------------------------
	task automatic line_read(input int line_no);
		int k;
		@(negedge clk);
		while (!line_rd_rdy)
			@(negedge clk);
		line_rd_req  = 1'b1;
		line_rd_addr = bridge_pkg::addr_t'(line_no * 64);
		line_rd_open = 1'b1;
		@(negedge clk);
		line_rd_req = 1'b0;
		k = 0;
		while (k < 16)
		begin
			@(posedge clk);
			if (line_ret_valid)
			begin
				compare_value("line_ret_data", line_ret_data, ref_mem[line_no * 16 + k]);
				compare_value("line_ret_last", 32'(line_ret_last), 32'(k == 15));
				k++;
			end
		end
		@(negedge clk);
		line_rd_open = 1'b0;
	endtask

	task automatic word_read(input int idx);
		bit done;
		@(negedge clk);
		while (!word_rd_rdy)
			@(negedge clk);
		exp_word_size = bridge_pkg::size_t'(next_rand() % 3);
		word_rd_req   = 1'b1;
		word_rd_addr  = bridge_pkg::addr_t'(idx * 4);
		word_rd_size  = exp_word_size;
		word_rd_open  = 1'b1;
		@(negedge clk);
		word_rd_req = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			if (word_ret_valid)
			begin
				compare_value("word_ret_data", word_ret_data, ref_mem[idx]);
				compare_value("word_ret_last", 32'(word_ret_last), 1);
				done = 1'b1;
			end
		end
		@(negedge clk);
		word_rd_open = 1'b0;
	endtask

	task automatic line_write(input int line_no);
		@(negedge clk);
		while (!line_wr_rdy)
			@(negedge clk);
		for (int k = 0; k < 16; k++)
			line_wr_data[32*k +: 32] = next_rand();
		line_wr_strb = bridge_pkg::strb_t'(next_rand());
		line_wr_addr = bridge_pkg::addr_t'(line_no * 64);
		line_wr_req  = 1'b1;
		b_seen[bridge_pkg::LINE_ID] = 1'b0;
		for (int k = 0; k < 16; k++)
			ref_mem[line_no * 16 + k] = merge(ref_mem[line_no * 16 + k],
				line_wr_data[32*k +: 32], line_wr_strb);
		@(negedge clk);
		line_wr_req = 1'b0;
		while (!line_wr_rdy)
			@(negedge clk);
		assert (b_seen[bridge_pkg::LINE_ID])
		else
		begin
			$display("line write finished before its write response");
			errors++;
		end
	endtask

	task automatic word_write(input int idx);
		@(negedge clk);
		while (!word_wr_rdy)
			@(negedge clk);
		word_wr_data     = next_rand();
		word_wr_strb     = bridge_pkg::strb_t'(next_rand() | 1);
		exp_word_wr_size = bridge_pkg::size_t'(next_rand() % 3);
		word_wr_size     = exp_word_wr_size;
		word_wr_addr     = bridge_pkg::addr_t'(idx * 4);
		word_wr_req      = 1'b1;
		b_seen[bridge_pkg::WORD_ID] = 1'b0;
		ref_mem[idx] = merge(ref_mem[idx], word_wr_data, word_wr_strb);
		@(negedge clk);
		word_wr_req = 1'b0;
		while (!word_wr_rdy)
			@(negedge clk);
		assert (b_seen[bridge_pkg::WORD_ID])
		else
		begin
			$display("word write finished before its write response");
			errors++;
		end
	endtask

	task automatic line_traffic();
		repeat (NUM_RAND)
		begin
			repeat (next_rand() % 4)
				@(negedge clk);
			if (next_rand() % 2 != 0)
				line_read(int'(next_rand() % 32));
			else
				line_write(int'(next_rand() % 32));
		end
	endtask

	task automatic word_traffic();
		repeat (NUM_RAND)
		begin
			repeat (next_rand() % 4)
				@(negedge clk);
			if (next_rand() % 2 != 0)
				word_read(512 + int'(next_rand() % 512));
			else
				word_write(512 + int'(next_rand() % 512));
		end
	endtask

	task automatic report(input string name, input int err_before);
		$display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
	endtask

	// run limit
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > LIMIT)
		begin
			$display("timeout after %0d cycles, a transaction never completed", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	//----------------------------------------------------------
	// test sequence
	//----------------------------------------------------------
	initial
	begin
		int e;
		{line_rd_req, line_wr_req, word_rd_req, word_wr_req} = '0;
		{line_rd_addr, line_wr_addr, word_rd_addr, word_wr_addr} = '0;
		{line_wr_strb, word_wr_strb, word_rd_size, word_wr_size} = '0;
		line_wr_data = '0;
		word_wr_data = '0;
		{arready, awready, wready, rvalid, rlast, bvalid} = '0;
		rid   = '0;
		bid   = '0;
		rdata = '0;
		exp_word_size    = '0;
		exp_word_wr_size = '0;
		for (int i = 0; i < 1024; i++)
		begin
			mem[i]     = (i * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
			ref_mem[i] = mem[i];
		end
		rst = 1'b0;
		repeat (4)
			@(negedge clk);
		rst = 1'b1;

		e = errors;
		line_read(3);
		report("line read", e);
		e = errors;
		word_read(700);
		report("word read", e);
		e = errors;
		line_write(5);
		line_read(5);
		report("line write", e);
		e = errors;
		word_write(801);
		word_read(801);
		report("word write", e);
		e = errors;
		fork
			line_traffic();
			word_traffic();
		join
		// slave contents against the reference
		for (int i = 0; i < 1024; i++)
			compare_value("mem", mem[i], ref_mem[i]);
		report("mixed traffic", e);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* tb_mem_bridge_assertions.sv */
//----------------------------------------------------------
// AXI master stability rules checked on the bridge top
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_mem_bridge_assertions (
	input logic               clk,
	input logic               rst,
	input logic               arvalid,
	input logic               arready,
	input bridge_pkg::id_t    arid,
	input bridge_pkg::addr_t  araddr,
	input bridge_pkg::len_t   arlen,
	input bridge_pkg::size_t  arsize,
	input logic               awvalid,
	input logic               awready,
	input bridge_pkg::id_t    awid,
	input bridge_pkg::addr_t  awaddr,
	input bridge_pkg::len_t   awlen,
	input bridge_pkg::size_t  awsize,
	input logic               wvalid,
	input logic               wlast
);

	ar_hold: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable({arid, araddr, arlen, arsize}))
		else $error("arvalid or its payload changed before arready");

	aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable({awid, awaddr, awlen, awsize}))
		else $error("awvalid or its payload changed before awready");

	wlast_valid: assert property (@(posedge clk) disable iff (!rst) wlast |-> wvalid)
		else $error("wlast high without wvalid");

endmodule

bind mem_bridge_top tb_mem_bridge_assertions protocol_check (
	.clk (clk), .rst (rst),
	.arvalid (arvalid), .arready (arready), .arid (arid),
	.araddr (araddr), .arlen (arlen), .arsize (arsize),
	.awvalid (awvalid), .awready (awready), .awid (awid),
	.awaddr (awaddr), .awlen (awlen), .awsize (awsize),
	.wvalid (wvalid), .wlast (wlast)
);

/* mem_bridge_top.sv */
//----------------------------------------------------------
// data-side bridge, a line port and a word port to one AXI
// line beats are always 4 bytes, bursts are INCR only
// lock, cache, prot, qos and response codes are not carried
//----------------------------------------------------------
`timescale 1ns/100ps

module mem_bridge_top (
	input  logic               clk,
	input  logic               rst,

	// line port
	input  logic               line_rd_req,
	input  bridge_pkg::addr_t  line_rd_addr,
	output logic               line_rd_rdy,
	output logic               line_ret_valid,
	output logic               line_ret_last,
	output bridge_pkg::word_t  line_ret_data,
	input  logic               line_wr_req,
	input  bridge_pkg::addr_t  line_wr_addr,
	input  bridge_pkg::strb_t  line_wr_strb,
	input  bridge_pkg::line_t  line_wr_data,
	output logic               line_wr_rdy,

	// word port
	input  logic               word_rd_req,
	input  bridge_pkg::addr_t  word_rd_addr,
	input  bridge_pkg::size_t  word_rd_size,
	output logic               word_rd_rdy,
	output logic               word_ret_valid,
	output logic               word_ret_last,
	output bridge_pkg::word_t  word_ret_data,
	input  logic               word_wr_req,
	input  bridge_pkg::addr_t  word_wr_addr,
	input  bridge_pkg::size_t  word_wr_size,
	input  bridge_pkg::strb_t  word_wr_strb,
	input  bridge_pkg::word_t  word_wr_data,
	output logic               word_wr_rdy,

	// AXI master
	output bridge_pkg::id_t    arid,
	output bridge_pkg::addr_t  araddr,
	output bridge_pkg::len_t   arlen,
	output bridge_pkg::size_t  arsize,
	output logic               arvalid,
	input  logic               arready,
	input  bridge_pkg::id_t    rid,
	input  bridge_pkg::word_t  rdata,
	input  logic               rlast,
	input  logic               rvalid,
	output logic               rready,
	output bridge_pkg::id_t    awid,
	output bridge_pkg::addr_t  awaddr,
	output bridge_pkg::len_t   awlen,
	output bridge_pkg::size_t  awsize,
	output logic               awvalid,
	input  logic               awready,
	output bridge_pkg::word_t  wdata,
	output bridge_pkg::strb_t  wstrb,
	output logic               wlast,
	output logic               wvalid,
	input  logic               wready,
	input  bridge_pkg::id_t    bid,
	input  logic               bvalid,
	output logic               bready
);

	bus_if line_bus ();
	bus_if word_bus ();

	//----------------------------------------------------------
	// port engines
	//----------------------------------------------------------
	port_engine #(
		.payload_t (bridge_pkg::line_t),
		.BEATS     (bridge_pkg::LINE_BEATS)
	) line_engine (
		.clk       (clk),
		.rst       (rst),
		.rd_req    (line_rd_req),
		.rd_addr   (line_rd_addr),
		.rd_size   (bridge_pkg::SIZE_WORD),  // full words only
		.rd_rdy    (line_rd_rdy),
		.ret_valid (line_ret_valid),
		.ret_last  (line_ret_last),
		.ret_data  (line_ret_data),
		.wr_req    (line_wr_req),
		.wr_addr   (line_wr_addr),
		.wr_size   (bridge_pkg::SIZE_WORD),
		.wr_strb   (line_wr_strb),
		.wr_data   (line_wr_data),
		.wr_rdy    (line_wr_rdy),
		.bus       (line_bus.engine)
	);

	port_engine #(
		.payload_t (bridge_pkg::word_t),
		.BEATS     (1)
	) word_engine (
		.clk       (clk),
		.rst       (rst),
		.rd_req    (word_rd_req),
		.rd_addr   (word_rd_addr),
		.rd_size   (word_rd_size),
		.rd_rdy    (word_rd_rdy),
		.ret_valid (word_ret_valid),
		.ret_last  (word_ret_last),
		.ret_data  (word_ret_data),
		.wr_req    (word_wr_req),
		.wr_addr   (word_wr_addr),
		.wr_size   (word_wr_size),
		.wr_strb   (word_wr_strb),
		.wr_data   (word_wr_data),
		.wr_rdy    (word_wr_rdy),
		.bus       (word_bus.engine)
	);

	//----------------------------------------------------------
	// arbiter onto the master port
	//----------------------------------------------------------
	axi_arbiter #(
		.ID0 (bridge_pkg::LINE_ID),
		.ID1 (bridge_pkg::WORD_ID)
	) arbiter (
		.clk     (clk),
		.rst     (rst),
		.bus0    (line_bus.arbiter),
		.bus1    (word_bus.arbiter),
		.arid    (arid),
		.araddr  (araddr),
		.arlen   (arlen),
		.arsize  (arsize),
		.arvalid (arvalid),
		.arready (arready),
		.rid     (rid),
		.rdata   (rdata),
		.rlast   (rlast),
		.rvalid  (rvalid),
		.rready  (rready),
		.awid    (awid),
		.awaddr  (awaddr),
		.awlen   (awlen),
		.awsize  (awsize),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wlast   (wlast),
		.wvalid  (wvalid),
		.wready  (wready),
		.bid     (bid),
		.bvalid  (bvalid),
		.bready  (bready)
	);

endmodule

/* axi_arbiter.sv */
//----------------------------------------------------------
// two engines merged onto one AXI master, INCR bursts only
// no new AW while a W burst runs, so W follows AW order
// R and B are steered by id, responses codes are not used
//----------------------------------------------------------
`timescale 1ns/100ps

module axi_arbiter #(
	parameter bridge_pkg::id_t ID0 = 4'd0,
	parameter bridge_pkg::id_t ID1 = 4'd1
) (
	input  logic               clk,
	input  logic               rst,
	bus_if.arbiter             bus0,
	bus_if.arbiter             bus1,

	output bridge_pkg::id_t    arid,
	output bridge_pkg::addr_t  araddr,
	output bridge_pkg::len_t   arlen,
	output bridge_pkg::size_t  arsize,
	output logic               arvalid,
	input  logic               arready,

	input  bridge_pkg::id_t    rid,
	input  bridge_pkg::word_t  rdata,
	input  logic               rlast,
	input  logic               rvalid,
	output logic               rready,

	output bridge_pkg::id_t    awid,
	output bridge_pkg::addr_t  awaddr,
	output bridge_pkg::len_t   awlen,
	output bridge_pkg::size_t  awsize,
	output logic               awvalid,
	input  logic               awready,

	output bridge_pkg::word_t  wdata,
	output bridge_pkg::strb_t  wstrb,
	output logic               wlast,
	output logic               wvalid,
	input  logic               wready,

	input  bridge_pkg::id_t    bid,
	input  logic               bvalid,
	output logic               bready
);

	logic        ar_hold, ar_hold_sel, ar_prio, ar_gnt, ar_fire;
	logic        aw_hold, aw_hold_sel, aw_prio, aw_gnt, aw_fire;
	logic        w_busy, w_sel, w_fire;
	logic        r_done, b_fire;
	logic [1:0]  rd_cnt, wr_cnt;

	//----------------------------------------------------------
	// read address grant
	//----------------------------------------------------------
	always_comb
	begin
		if (ar_hold)
			ar_gnt = ar_hold_sel;  // keep payload stable under stall
		else if (bus0.ar_valid && bus1.ar_valid)
			ar_gnt = ar_prio;
		else
			ar_gnt = bus1.ar_valid;
	end

	assign arvalid = ar_gnt ? bus1.ar_valid : bus0.ar_valid;
	assign arid    = ar_gnt ? ID1 : ID0;
	assign araddr  = ar_gnt ? bus1.ar_addr : bus0.ar_addr;
	assign arlen   = ar_gnt ? bus1.ar_len : bus0.ar_len;
	assign arsize  = ar_gnt ? bus1.ar_size : bus0.ar_size;
	assign ar_fire = arvalid && arready;

	assign bus0.ar_ready = arready && !ar_gnt;
	assign bus1.ar_ready = arready && ar_gnt;

	//----------------------------------------------------------
	// write address grant, blocked while W is owned
	//----------------------------------------------------------
	always_comb
	begin
		if (aw_hold)
			aw_gnt = aw_hold_sel;
		else if (bus0.aw_valid && bus1.aw_valid)
			aw_gnt = aw_prio;
		else
			aw_gnt = bus1.aw_valid;
	end

	assign awvalid = !w_busy && (aw_gnt ? bus1.aw_valid : bus0.aw_valid);
	assign awid    = aw_gnt ? ID1 : ID0;
	assign awaddr  = aw_gnt ? bus1.aw_addr : bus0.aw_addr;
	assign awlen   = aw_gnt ? bus1.aw_len : bus0.aw_len;
	assign awsize  = aw_gnt ? bus1.aw_size : bus0.aw_size;
	assign aw_fire = awvalid && awready;

	assign bus0.aw_ready = awready && !w_busy && !aw_gnt;
	assign bus1.aw_ready = awready && !w_busy && aw_gnt;

	// W owner follows the last accepted AW
	assign wvalid = w_busy && (w_sel ? bus1.w_valid : bus0.w_valid);
	assign wdata  = w_sel ? bus1.w_data : bus0.w_data;
	assign wstrb  = w_sel ? bus1.w_strb : bus0.w_strb;
	assign wlast  = w_sel ? bus1.w_last : bus0.w_last;
	assign w_fire = wvalid && wready;

	assign bus0.w_ready = wready && w_busy && !w_sel;
	assign bus1.w_ready = wready && w_busy && w_sel;

	//----------------------------------------------------------
	// grant and outstanding state
	//----------------------------------------------------------
	assign r_done = rvalid && rready && rlast;
	assign b_fire = bvalid && bready;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			ar_hold     <= 1'b0;
			ar_hold_sel <= 1'b0;
			ar_prio     <= 1'b0;
			aw_hold     <= 1'b0;
			aw_hold_sel <= 1'b0;
			aw_prio     <= 1'b0;
			w_busy      <= 1'b0;
			w_sel       <= 1'b0;
			rd_cnt      <= 2'd0;
			wr_cnt      <= 2'd0;
		end
		else
		begin
			if (ar_fire)
			begin
				ar_hold <= 1'b0;
				ar_prio <= !ar_gnt;  // other side first next time
			end
			else if (arvalid)
			begin
				ar_hold     <= 1'b1;
				ar_hold_sel <= ar_gnt;
			end

			if (aw_fire)
			begin
				aw_hold <= 1'b0;
				aw_prio <= !aw_gnt;
				w_busy  <= 1'b1;
				w_sel   <= aw_gnt;
			end
			else if (awvalid)
			begin
				aw_hold     <= 1'b1;
				aw_hold_sel <= aw_gnt;
			end

			if (w_fire && wlast)
				w_busy <= 1'b0;

			rd_cnt <= rd_cnt + 2'(ar_fire) - 2'(r_done);
			wr_cnt <= wr_cnt + 2'(aw_fire) - 2'(b_fire);
		end
	end

	assign rready = (rd_cnt != 2'd0);
	assign bready = (wr_cnt != 2'd0);

	// response steering by id
	assign bus0.r_valid = rvalid && rready && (rid == ID0);
	assign bus1.r_valid = rvalid && rready && (rid == ID1);
	assign bus0.r_data  = rdata;
	assign bus1.r_data  = rdata;
	assign bus0.r_last  = rlast;
	assign bus1.r_last  = rlast;
	assign bus0.b_valid = b_fire && (bid == ID0);
	assign bus1.b_valid = b_fire && (bid == ID1);

endmodule

/* port_engine.sv */
//----------------------------------------------------------
// one requester port turned into AXI reads and writes
// one transaction open at a time, a read wins over a write
// payload_t is BEATS words wide, strobe applies to every beat
//----------------------------------------------------------
`timescale 1ns/100ps

module port_engine #(
	parameter type payload_t = bridge_pkg::word_t,
	parameter int  BEATS     = 1
) (
	input  logic               clk,
	input  logic               rst,

	input  logic               rd_req,
	input  bridge_pkg::addr_t  rd_addr,
	input  bridge_pkg::size_t  rd_size,
	output logic               rd_rdy,
	output logic               ret_valid,
	output logic               ret_last,
	output bridge_pkg::word_t  ret_data,

	input  logic               wr_req,
	input  bridge_pkg::addr_t  wr_addr,
	input  bridge_pkg::size_t  wr_size,
	input  bridge_pkg::strb_t  wr_strb,
	input  payload_t           wr_data,
	output logic               wr_rdy,

	bus_if.engine              bus
);

	localparam int CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD_ADDR,
		S_RD_DATA,
		S_WR_ADDR,
		S_WR_DATA,
		S_WR_RESP
	} state_t;

	state_t             state;
	bridge_pkg::addr_t  addr_q;
	bridge_pkg::size_t  size_q;
	bridge_pkg::strb_t  strb_q;
	payload_t           data_q;
	logic [CNT_W-1:0]   beat_cnt;
	logic               idle;
	logic               w_fire;

	assign idle   = (state == S_IDLE);
	assign w_fire = bus.w_valid && bus.w_ready;

	//----------------------------------------------------------
	// state machine
	//----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state    <= S_IDLE;
			beat_cnt <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					beat_cnt <= '0;
					if (rd_req)
						state <= S_RD_ADDR;
					else if (wr_req)
						state <= S_WR_ADDR;
				end
				S_RD_ADDR:
					if (bus.ar_ready)
						state <= S_RD_DATA;
				S_RD_DATA:
					if (bus.r_valid && bus.r_last)
						state <= S_IDLE;  // rdy back next cycle
				S_WR_ADDR:
					if (bus.aw_ready)
						state <= S_WR_DATA;
				S_WR_DATA:
					if (w_fire)
					begin
						beat_cnt <= beat_cnt + 1'b1;
						if (bus.w_last)
							state <= S_WR_RESP;
					end
				S_WR_RESP:
					if (bus.b_valid)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// request capture and write data shifter
	always_ff @(posedge clk)
	begin
		if (idle && rd_req)
		begin
			addr_q <= rd_addr;
			size_q <= rd_size;
		end
		else if (idle && wr_req)
		begin
			addr_q <= wr_addr;
			size_q <= wr_size;
			strb_q <= wr_strb;
			data_q <= wr_data;
		end
		else if (state == S_WR_DATA && w_fire)
			data_q <= data_q >> $bits(bridge_pkg::word_t);  // next word down
	end

	//----------------------------------------------------------
	// bus side
	//----------------------------------------------------------
	assign bus.ar_valid = (state == S_RD_ADDR);
	assign bus.ar_addr  = addr_q;
	assign bus.ar_size  = size_q;
	assign bus.ar_len   = bridge_pkg::len_t'(BEATS - 1);

	assign bus.aw_valid = (state == S_WR_ADDR);
	assign bus.aw_addr  = addr_q;
	assign bus.aw_size  = size_q;
	assign bus.aw_len   = bridge_pkg::len_t'(BEATS - 1);

	assign bus.w_valid  = (state == S_WR_DATA);
	assign bus.w_data   = bridge_pkg::word_t'(data_q);  // low word of shifter
	assign bus.w_strb   = strb_q;
	assign bus.w_last   = bus.w_valid && (beat_cnt == CNT_W'(BEATS - 1));

	// requester side
	assign rd_rdy    = idle;
	assign wr_rdy    = idle;
	assign ret_valid = (state == S_RD_DATA) && bus.r_valid;
	assign ret_last  = ret_valid && bus.r_last;
	assign ret_data  = bus.r_data;

endmodule

/* bus_if.sv */
//----------------------------------------------------------
// AXI-like link from one port engine to the arbiter
// no id fields here, the arbiter tags and strips them
// r and b have no ready, the engine takes every beat
//----------------------------------------------------------
`timescale 1ns/100ps

interface bus_if;

	// read address
	logic                ar_valid;
	logic                ar_ready;
	bridge_pkg::addr_t   ar_addr;
	bridge_pkg::size_t   ar_size;
	bridge_pkg::len_t    ar_len;

	// read data, already filtered by id
	logic                r_valid;
	bridge_pkg::word_t   r_data;
	logic                r_last;

	// write address
	logic                aw_valid;
	logic                aw_ready;
	bridge_pkg::addr_t   aw_addr;
	bridge_pkg::size_t   aw_size;
	bridge_pkg::len_t    aw_len;

	// write data
	logic                w_valid;
	logic                w_ready;
	bridge_pkg::word_t   w_data;
	bridge_pkg::strb_t   w_strb;
	logic                w_last;

	// write response, filtered by id
	logic                b_valid;

	modport engine (
		output ar_valid, ar_addr, ar_size, ar_len,
		output aw_valid, aw_addr, aw_size, aw_len,
		output w_valid, w_data, w_strb, w_last,
		input  ar_ready, aw_ready, w_ready,
		input  r_valid, r_data, r_last,
		input  b_valid
	);

	modport arbiter (
		input  ar_valid, ar_addr, ar_size, ar_len,
		input  aw_valid, aw_addr, aw_size, aw_len,
		input  w_valid, w_data, w_strb, w_last,
		output ar_ready, aw_ready, w_ready,
		output r_valid, r_data, r_last,
		output b_valid
	);

endinterface

/* bridge_pkg.sv */
//----------------------------------------------------------
// widths, ids and payload types of the data-side AXI bridge
// bursts are INCR only and every bus beat is one 32-bit word
// a cache line is LINE_BEATS words, sent low word first
//----------------------------------------------------------
package bridge_pkg;

	//----------------------------------------------------------
	// bus field types
	//----------------------------------------------------------
	typedef logic [31:0] addr_t;  // byte address
	typedef logic [31:0] word_t;  // one data beat
	typedef logic [3:0]  strb_t;  // byte strobes of one beat
	typedef logic [2:0]  size_t;  // AXI size code
	typedef logic [3:0]  len_t;   // AXI burst length minus one
	typedef logic [3:0]  id_t;    // AXI transaction id

	//----------------------------------------------------------
	// line geometry
	//----------------------------------------------------------
	localparam int LINE_BEATS = 16;  // words per cache line

	typedef logic [LINE_BEATS*32-1:0] line_t;  // 512-bit cache line

	//----------------------------------------------------------
	// fixed ids and codes
	//----------------------------------------------------------
	localparam id_t   LINE_ID   = 4'd1;  // line port transactions
	localparam id_t   WORD_ID   = 4'd2;  // word port transactions
	localparam size_t SIZE_WORD = 3'd2;  // 4 bytes per beat

endpackage
